//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = rv_core_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = >>> PASS

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/rv_core_tb.sv
module rv_core_tb;

    localparam int stim_words = 256;
    localparam int imem_idx_w = 6;
    localparam int imem_words = 1 << imem_idx_w;
    localparam logic [31:0] kind_wb = 32'd1;
    localparam logic [31:0] kind_st = 32'd2;

    logic                          clk;
    logic                          arst_n;
    logic [rv_pkg::xlen-1:0]       imem_data;
    logic [rv_pkg::xlen-1:0]       imem_addr;
    logic                          wb_valid;
    logic [rv_pkg::reg_addr_w-1:0] wb_rd;
    logic [rv_pkg::xlen-1:0]       wb_data;
    logic                          st_valid;
    logic [rv_pkg::xlen-1:0]       st_addr;
    logic [rv_pkg::xlen-1:0]       st_data;
    logic [3:0]                    st_mask;

    logic [31:0]                   stim [stim_words];
    logic [rv_pkg::xlen-1:0]       imem [imem_words];
    logic [rv_pkg::xlen-1:0]       halt_addr;
    int                            prog_len;
    int                            exp_count;
    int                            exp_base;
    int                            exp_next;
    int                            pass_count;
    int                            fail_count;
    int                            cycle_count;
    int                            cycle_limit;

    rv_core rv_core_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .st_valid  (st_valid),
        .st_addr   (st_addr),
        .st_data   (st_data),
        .st_mask   (st_mask)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Instruction memory answers the PC on the falling edge
    always @(negedge clk) begin
        imem_data = imem[imem_addr[imem_idx_w+1:2]];
    end

    task automatic check_wb(input int                            idx,
                            input logic [rv_pkg::reg_addr_w-1:0] exp_rd,
                            input logic [rv_pkg::xlen-1:0]       exp_data,
                            input logic [rv_pkg::reg_addr_w-1:0] got_rd,
                            input logic [rv_pkg::xlen-1:0]       got_data);
        logic ok;
        ok = 1'b1;
        if (got_rd !== exp_rd) begin
            $display("MISMATCH t=%0t wb_rd expected %0d actual %0d", $time, exp_rd, got_rd);
            ok = 1'b0;
        end
        if (got_data !== exp_data) begin
            $display("MISMATCH t=%0t wb_data expected %h actual %h", $time, exp_data, got_data);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
            $display("record %0d ok, x%0d <= %h", idx, got_rd, got_data);
        end else begin
            fail_count++;
            $display("record %0d failed, register commit", idx);
        end
    endtask

    task automatic check_st(input int                      idx,
                            input logic [rv_pkg::xlen-1:0] exp_addr,
                            input logic [rv_pkg::xlen-1:0] exp_data,
                            input logic [3:0]              exp_mask,
                            input logic [rv_pkg::xlen-1:0] got_addr,
                            input logic [rv_pkg::xlen-1:0] got_data,
                            input logic [3:0]              got_mask);
        logic ok;
        ok = 1'b1;
        if (got_addr !== exp_addr) begin
            $display("MISMATCH t=%0t st_addr expected %h actual %h", $time, exp_addr, got_addr);
            ok = 1'b0;
        end
        if (got_data !== exp_data) begin
            $display("MISMATCH t=%0t st_data expected %h actual %h", $time, exp_data, got_data);
            ok = 1'b0;
        end
        if (got_mask !== exp_mask) begin
            $display("MISMATCH t=%0t st_mask expected %h actual %h", $time, exp_mask, got_mask);
            ok = 1'b0;
        end
        if (ok) begin
            pass_count++;
            $display("record %0d ok, store %h mask %h at %h", idx, got_data, got_mask, got_addr);
        end else begin
            fail_count++;
            $display("record %0d failed, store", idx);
        end
    endtask

    // Next expected record goes to the compare of its kind
    task automatic take_commit(input logic is_store);
        int          base;
        logic [31:0] kind;
        if (exp_next >= exp_count) begin
            $display("Unexpected %s commit at t=%0t with no expected record left",
                     is_store ? "store" : "register", $time);
            fail_count++;
        end else begin
            base = exp_base + 4 * exp_next;
            kind = stim[base];
            if (is_store && kind == kind_st) begin
                check_st(exp_next, stim[base+1], stim[base+2], stim[base+3][3:0],
                         st_addr, st_data, st_mask);
            end else if (!is_store && kind == kind_wb) begin
                check_wb(exp_next, stim[base+1][rv_pkg::reg_addr_w-1:0], stim[base+2],
                         wb_rd, wb_data);
            end else begin
                $display("Record %0d failed, the core made a %s commit at t=%0t instead",
                         exp_next, is_store ? "store" : "register", $time);
                fail_count++;
            end
            exp_next++;
        end
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            cycle_count = cycle_count + 1;
            if (wb_valid) begin
                take_commit(1'b0);
            end
            if (st_valid) begin
                take_commit(1'b1);
            end
        end else if (wb_valid || st_valid) begin
            $display("Commit trace was active during reset at t=%0t", $time);
            fail_count++;
        end
    end

    initial begin
        arst_n      = 1'b0;
        imem_data   = '0;
        exp_next    = 0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        void'($urandom(32'hb8cd_8989));
        $readmemh("tb/rv_stim.txt", stim);
        prog_len    = int'(stim[0]);
        exp_count   = int'(stim[prog_len + 1]);
        exp_base    = prog_len + 2;
        halt_addr   = 32'(4 * (prog_len - 1));
        cycle_limit = prog_len * 4 + 20;

        // Slots past the program are never fetched
        for (int k = 0; k < imem_words; k++) begin
            imem[k] = $urandom();
        end
        for (int k = 0; k < prog_len; k++) begin
            imem[k] = stim[k + 1];
        end

        repeat (10) @(negedge clk);
        arst_n = 1'b1;

        // Program ends in a jump-to-self
        while (imem_addr !== halt_addr && cycle_count < cycle_limit) begin
            @(negedge clk);
        end
        if (imem_addr !== halt_addr) begin
            $display("Timeout after %0d cycles, the core never reached the halt loop",
                     cycle_count);
            fail_count++;
        end
        if (exp_next < exp_count) begin
            $display("%0d expected records were never matched by a commit",
                     exp_count - exp_next);
            fail_count++;
        end
        $display("Finished with %0d checks passed and %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb/rv_stim.txt
// First word is the program length N, then N instruction words ending in a jump-to-self
// Then the record count M and M records of four words (kind, rd or address, value, mask)
// Kind 1 is a register commit with mask 0, kind 2 is a store
2c
00500093 // 00 addi x1, x0, 5
ffd00113 // 04 addi x2, x0, -3
402081b3 // 08 sub x3, x1, x2
40115213 // 0c srai x4, x2, 1
001152b3 // 10 srl x5, x2, x1
00112333 // 14 slt x6, x2, x1
001133b3 // 18 sltu x7, x2, x1
12345437 // 1c lui x8, 0x12345
00001497 // 20 auipc x9, 1
00708013 // 24 addi x0, x1, 7
00100533 // 28 add x10, x0, x1
10000593 // 2c addi x11, x0, 0x100
0085a023 // 30 sw x8, 0(x11)
002582a3 // 34 sb x2, 5(x11)
00259323 // 38 sh x2, 6(x11)
00558603 // 3c lb x12, 5(x11)
0055c683 // 40 lbu x13, 5(x11)
00659703 // 44 lh x14, 6(x11)
0065d783 // 48 lhu x15, 6(x11)
0005a803 // 4c lw x16, 0(x11)
00208463 // 50 beq x1, x2, +8 not taken
00a08463 // 54 beq x1, x10, +8 taken
00100f93 // 58 addi x31, x0, 1 skipped
00a09463 // 5c bne x1, x10, +8 not taken
00209463 // 60 bne x1, x2, +8 taken
00200f93 // 64 addi x31, x0, 2 skipped
0020c463 // 68 blt x1, x2, +8 not taken
00114463 // 6c blt x2, x1, +8 taken
00300f93 // 70 addi x31, x0, 3 skipped
00115463 // 74 bge x2, x1, +8 not taken
0020d463 // 78 bge x1, x2, +8 taken
00400f93 // 7c addi x31, x0, 4 skipped
00116463 // 80 bltu x2, x1, +8 not taken
0020e463 // 84 bltu x1, x2, +8 taken
00500f93 // 88 addi x31, x0, 5 skipped
0020f463 // 8c bgeu x1, x2, +8 not taken
00117463 // 90 bgeu x2, x1, +8 taken
00600f93 // 94 addi x31, x0, 6 skipped
008008ef // 98 jal x17, +8
00700f93 // 9c addi x31, x0, 7 skipped
00d88967 // a0 jalr x18, 13(x17) lands on a8
00800f93 // a4 addi x31, x0, 8 skipped
00190993 // a8 addi x19, x18, 1
0000006f // ac jal x0, 0
16
1 01 00000005 0
1 02 fffffffd 0
1 03 00000008 0
1 04 fffffffe 0
1 05 07ffffff 0
1 06 00000001 0
1 07 00000000 0
1 08 12345000 0
1 09 00001020 0
1 0a 00000005 0
1 0b 00000100 0
2 00000100 12345000 f
2 00000104 0000fd00 2
2 00000104 fffd0000 c
1 0c fffffffd 0
1 0d 000000fd 0
1 0e fffffffd 0
1 0f 0000fffd 0
1 10 12345000 0
1 11 0000009c 0
1 12 000000a4 0
1 13 000000a5 0

//--- verilog/rv_alu.sv
module rv_alu (
    input  logic [rv_pkg::xlen-1:0]     a,
    input  logic [rv_pkg::xlen-1:0]     b,
    input  logic [rv_pkg::alu_op_w-1:0] alu_op,
    input  logic [2:0]                  funct3,
    output logic [rv_pkg::xlen-1:0]     result,
    output logic                        branch_taken
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign eq    = (a == b);
    assign lt_s  = ($signed(a) < $signed(b));
    assign lt_u  = (a < b);

    always_comb begin
        case (alu_op)
            rv_pkg::alu_add:    result = a + b;
            rv_pkg::alu_sub:    result = a - b;
            rv_pkg::alu_sll:    result = a << shamt;
            rv_pkg::alu_slt:    result = {{(rv_pkg::xlen-1){1'b0}}, lt_s};
            rv_pkg::alu_sltu:   result = {{(rv_pkg::xlen-1){1'b0}}, lt_u};
            rv_pkg::alu_xor:    result = a ^ b;
            rv_pkg::alu_srl:    result = a >> shamt;
            rv_pkg::alu_sra:    result = $unsigned($signed(a) >>> shamt);
            rv_pkg::alu_or:     result = a | b;
            rv_pkg::alu_and:    result = a & b;
            rv_pkg::alu_pass_b: result = b;
            default:            result = '0;
        endcase
    end

    // Only valid while the decoder flags a branch
    always_comb begin
        case (funct3)
            rv_pkg::f3_beq:  branch_taken = eq;
            rv_pkg::f3_bne:  branch_taken = !eq;
            rv_pkg::f3_blt:  branch_taken = lt_s;
            rv_pkg::f3_bge:  branch_taken = !lt_s;
            rv_pkg::f3_bltu: branch_taken = lt_u;
            rv_pkg::f3_bgeu: branch_taken = !lt_u;
            default:         branch_taken = 1'b0;
        endcase
    end

endmodule

//--- verilog/rv_core.sv
module rv_core (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [rv_pkg::xlen-1:0]       imem_data,
    output logic [rv_pkg::xlen-1:0]       imem_addr,
    output logic                          wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]       wb_data,
    output logic                          st_valid,
    output logic [rv_pkg::xlen-1:0]       st_addr,
    output logic [rv_pkg::xlen-1:0]       st_data,
    output logic [3:0]                    st_mask
);

    logic [rv_pkg::xlen-1:0]     pc;
    logic [rv_pkg::xlen-1:0]     next_pc;
    logic [rv_pkg::xlen-1:0]     pc_plus4;
    logic [rv_pkg::xlen-1:0]     pc_target;
    rv_pkg::rv_instr_u           instr;
    logic [rv_pkg::src_a_w-1:0]  src_a_sel;
    logic [rv_pkg::src_b_w-1:0]  src_b_sel;
    logic [rv_pkg::wb_sel_w-1:0] wb_sel;
    logic [rv_pkg::alu_op_w-1:0] alu_op;
    logic [rv_pkg::xlen-1:0]     imm;
    logic                        rf_we;
    logic                        mem_read;
    logic                        mem_write;
    logic                        jump;
    logic                        jalr;
    logic                        branch;
    logic [2:0]                  funct3;
    logic [rv_pkg::xlen-1:0]     rdata1;
    logic [rv_pkg::xlen-1:0]     rdata2;
    logic [rv_pkg::xlen-1:0]     op_a;
    logic [rv_pkg::xlen-1:0]     op_b;
    logic [rv_pkg::xlen-1:0]     alu_result;
    logic                        branch_taken;
    logic [rv_pkg::xlen-1:0]     load_data;
    logic [rv_pkg::xlen-1:0]     rd_wdata;

    assign instr     = imem_data;
    assign imem_addr = pc;
    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    always_comb begin
        if (jalr) begin
            next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};
        end else if (jump || (branch && branch_taken)) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    rv_decoder rv_decoder_i (
        .instr     (instr),
        .src_a_sel (src_a_sel),
        .src_b_sel (src_b_sel),
        .wb_sel    (wb_sel),
        .alu_op    (alu_op),
        .imm       (imm),
        .rf_we     (rf_we),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .jump      (jump),
        .jalr      (jalr),
        .branch    (branch),
        .funct3    (funct3)
    );

    rv_regfile rv_regfile_i (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (instr.r.rs1),
        .rs2    (instr.r.rs2),
        .rd     (instr.r.rd),
        .we     (rf_we),
        .wdata  (rd_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    always_comb begin
        case (src_a_sel)
            rv_pkg::src_a_rs1: op_a = rdata1;
            rv_pkg::src_a_pc:  op_a = pc;
            default:           op_a = '0;
        endcase
    end

    assign op_b = (src_b_sel == rv_pkg::src_b_imm) ? imm : rdata2;

    rv_alu rv_alu_i (
        .a            (op_a),
        .b            (op_b),
        .alu_op       (alu_op),
        .funct3       (funct3),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    rv_lsu rv_lsu_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .funct3       (funct3),
        .addr         (alu_result),
        .store_src    (rdata2),
        .load_data    (load_data),
        .st_data      (st_data),
        .st_mask      (st_mask),
        .st_word_addr (st_addr)
    );

    always_comb begin
        case (wb_sel)
            rv_pkg::wb_load: rd_wdata = load_data;
            rv_pkg::wb_pc4:  rd_wdata = pc_plus4;
            default:         rd_wdata = alu_result;
        endcase
    end

    // Commit trace for the instruction at imem_addr
    assign wb_valid = arst_n && rf_we && (instr.r.rd != '0);
    assign wb_rd    = instr.r.rd;
    assign wb_data  = rd_wdata;
    assign st_valid = arst_n && mem_write;

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

//--- verilog/rv_decoder.sv
module rv_decoder (
    input  rv_pkg::rv_instr_u               instr,
    output logic [rv_pkg::src_a_w-1:0]      src_a_sel,
    output logic [rv_pkg::src_b_w-1:0]      src_b_sel,
    output logic [rv_pkg::wb_sel_w-1:0]     wb_sel,
    output logic [rv_pkg::alu_op_w-1:0]     alu_op,
    output logic [rv_pkg::xlen-1:0]         imm,
    output logic                            rf_we,
    output logic                            mem_read,
    output logic                            mem_write,
    output logic                            jump,
    output logic                            jalr,
    output logic                            branch,
    output logic [2:0]                      funct3
);

    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_s;
    logic [rv_pkg::xlen-1:0] imm_b;
    logic [rv_pkg::xlen-1:0] imm_u;
    logic [rv_pkg::xlen-1:0] imm_j;
    logic                    alt_op;

    assign funct3 = instr.r.funct3;

    assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
    assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
    assign imm_u = {instr.u.imm_31_12, 12'b0};
    assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                    instr.j.imm_11, instr.j.imm_10_1, 1'b0};

    // Bit 30 means SUB only on OP, SRA on both forms
    assign alt_op = instr.r.funct7[5] &&
                    ((instr.r.funct3 == 3'b101) ||
                     (instr.r.funct3 == 3'b000 && instr.r.opcode == rv_pkg::op_reg));

    always_comb begin
        src_a_sel = rv_pkg::src_a_rs1;
        src_b_sel = rv_pkg::src_b_rs2;
        wb_sel    = rv_pkg::wb_alu;
        alu_op    = rv_pkg::alu_add;
        imm       = '0;
        rf_we     = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        jump      = 1'b0;
        jalr      = 1'b0;
        branch    = 1'b0;
        case (instr.r.opcode)
            rv_pkg::op_lui: begin
                src_a_sel = rv_pkg::src_a_zero;
                src_b_sel = rv_pkg::src_b_imm;
                alu_op    = rv_pkg::alu_pass_b;
                imm       = imm_u;
                rf_we     = 1'b1;
            end
            rv_pkg::op_auipc: begin
                src_a_sel = rv_pkg::src_a_pc;
                src_b_sel = rv_pkg::src_b_imm;
                imm       = imm_u;
                rf_we     = 1'b1;
            end
            rv_pkg::op_jal: begin
                wb_sel = rv_pkg::wb_pc4;
                imm    = imm_j;
                rf_we  = 1'b1;
                jump   = 1'b1;
            end
            rv_pkg::op_jalr: begin
                // ALU forms rs1 + imm as the target
                src_b_sel = rv_pkg::src_b_imm;
                wb_sel    = rv_pkg::wb_pc4;
                imm       = imm_i;
                rf_we     = 1'b1;
                jalr      = 1'b1;
            end
            rv_pkg::op_branch: begin
                alu_op = rv_pkg::alu_sub;
                imm    = imm_b;
                branch = 1'b1;
            end
            rv_pkg::op_load: begin
                src_b_sel = rv_pkg::src_b_imm;
                wb_sel    = rv_pkg::wb_load;
                imm       = imm_i;
                rf_we     = 1'b1;
                mem_read  = 1'b1;
            end
            rv_pkg::op_store: begin
                src_b_sel = rv_pkg::src_b_imm;
                imm       = imm_s;
                mem_write = 1'b1;
            end
            rv_pkg::op_imm: begin
                src_b_sel = rv_pkg::src_b_imm;
                alu_op    = {alt_op, instr.r.funct3};
                imm       = imm_i;
                rf_we     = 1'b1;
            end
            rv_pkg::op_reg: begin
                alu_op = {alt_op, instr.r.funct3};
                rf_we  = 1'b1;
            end
            default: begin
                // Unknown opcode, PC just advances
            end
        endcase
    end

    a_mem_excl: assert property (@(instr) !(mem_read && mem_write));

endmodule

//--- verilog/rv_lsu.sv
module rv_lsu (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    mem_read,
    input  logic                    mem_write,
    input  logic [2:0]              funct3,
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] store_src,
    output logic [rv_pkg::xlen-1:0] load_data,
    output logic [rv_pkg::xlen-1:0] st_data,
    output logic [3:0]              st_mask,
    output logic [rv_pkg::xlen-1:0] st_word_addr
);

    logic [rv_pkg::xlen-1:0]       mem [rv_pkg::dmem_words];
    logic [rv_pkg::dmem_idx_w-1:0] idx;
    logic [4:0]                    lane_shift;
    logic [rv_pkg::xlen-1:0]       rd_word;
    logic [rv_pkg::xlen-1:0]       rd_lane;
    logic [rv_pkg::xlen-1:0]       load_ext;

    assign idx          = addr[rv_pkg::dmem_idx_w+1:2];
    assign lane_shift   = {addr[1:0], 3'b000};
    assign st_word_addr = {addr[rv_pkg::xlen-1:2], 2'b00};

    // Move store data into its byte lane
    always_comb begin
        case (funct3)
            rv_pkg::f3_byte: begin
                st_data = {24'b0, store_src[7:0]} << lane_shift;
                st_mask = 4'b0001 << addr[1:0];
            end
            rv_pkg::f3_half: begin
                st_data = {16'b0, store_src[15:0]} << lane_shift;
                st_mask = 4'b0011 << addr[1:0];
            end
            default: begin
                st_data = store_src;
                st_mask = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (arst_n && mem_write) begin
            for (int k = 0; k < 4; k++) begin
                if (st_mask[k]) begin
                    mem[idx][8*k +: 8] <= st_data[8*k +: 8];
                end
            end
        end
    end

    assign rd_word = mem[idx];
    assign rd_lane = rd_word >> lane_shift;

    always_comb begin
        case (funct3)
            rv_pkg::f3_byte:   load_ext = {{24{rd_lane[7]}}, rd_lane[7:0]};
            rv_pkg::f3_byte_u: load_ext = {24'b0, rd_lane[7:0]};
            rv_pkg::f3_half:   load_ext = {{16{rd_lane[15]}}, rd_lane[15:0]};
            rv_pkg::f3_half_u: load_ext = {16'b0, rd_lane[15:0]};
            default:           load_ext = rd_word;
        endcase
    end

    assign load_data = mem_read ? load_ext : '0;

    // Natural alignment for halfword and word
    a_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_read || mem_write) |->
            !(addr[0] && funct3[1:0] != rv_pkg::f3_byte[1:0]) &&
            !(addr[1] && funct3[1:0] == rv_pkg::f3_word[1:0]));

endmodule

//--- verilog/rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int dmem_words = 1024;
    localparam int dmem_idx_w = $clog2(dmem_words);

    // Major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // Load and store sizes
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    // Branch conditions
    localparam logic [2:0] f3_beq    = 3'b000;
    localparam logic [2:0] f3_bne    = 3'b001;
    localparam logic [2:0] f3_blt    = 3'b100;
    localparam logic [2:0] f3_bge    = 3'b101;
    localparam logic [2:0] f3_bltu   = 3'b110;
    localparam logic [2:0] f3_bgeu   = 3'b111;

    // Low three bits match funct3 of OP and OP-IMM, bit 3 is instruction bit 30
    localparam int alu_op_w = 4;
    localparam logic [alu_op_w-1:0] alu_add    = 4'b0000;
    localparam logic [alu_op_w-1:0] alu_sll    = 4'b0001;
    localparam logic [alu_op_w-1:0] alu_slt    = 4'b0010;
    localparam logic [alu_op_w-1:0] alu_sltu   = 4'b0011;
    localparam logic [alu_op_w-1:0] alu_xor    = 4'b0100;
    localparam logic [alu_op_w-1:0] alu_srl    = 4'b0101;
    localparam logic [alu_op_w-1:0] alu_or     = 4'b0110;
    localparam logic [alu_op_w-1:0] alu_and    = 4'b0111;
    localparam logic [alu_op_w-1:0] alu_sub    = 4'b1000;
    localparam logic [alu_op_w-1:0] alu_sra    = 4'b1101;
    localparam logic [alu_op_w-1:0] alu_pass_b = 4'b1111;

    localparam int src_a_w = 2;
    localparam logic [src_a_w-1:0] src_a_rs1  = 2'd0;
    localparam logic [src_a_w-1:0] src_a_pc   = 2'd1;
    localparam logic [src_a_w-1:0] src_a_zero = 2'd2;

    localparam int src_b_w = 1;
    localparam logic [src_b_w-1:0] src_b_rs2 = 1'b0;
    localparam logic [src_b_w-1:0] src_b_imm = 1'b1;

    localparam int wb_sel_w = 2;
    localparam logic [wb_sel_w-1:0] wb_alu  = 2'd0;
    localparam logic [wb_sel_w-1:0] wb_load = 2'd1;
    localparam logic [wb_sel_w-1:0] wb_pc4  = 2'd2;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } rv_i_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } rv_s_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } rv_b_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } rv_u_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } rv_j_t;

    typedef union packed {
        rv_r_t r;
        rv_i_t i;
        rv_s_t s;
        rv_b_t b;
        rv_u_t u;
        rv_j_t j;
    } rv_instr_u;

endpackage

//--- verilog/rv_regfile.sv
module rv_regfile (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2,
    input  logic [rv_pkg::reg_addr_w-1:0] rd,
    input  logic                          we,
    input  logic [rv_pkg::xlen-1:0]       wdata,
    output logic [rv_pkg::xlen-1:0]       rdata1,
    output logic [rv_pkg::xlen-1:0]       rdata2
);

    logic [rv_pkg::xlen-1:0] regs [1 << rv_pkg::reg_addr_w];

    // x0 is never stored
    always_ff @(posedge clk) begin
        if (arst_n && we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    // Storage behind x0 never takes a write
    a_x0_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        regs[0] === $past(regs[0]));

endmodule

//--- vlog.f
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
tb/rv_core_tb.sv
